// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - design/i2c_master_pkg.sv
  - design/i2c_scl_gen.sv
  - design/i2c_sequencer.sv
  - design/i2c_byte_shifter.sv
  - design/i2c_master_top.sv
  - target: test
    files:
      - dv/i2c_slave_model.sv
      - dv/tb_i2c_master.sv

// ==== design/i2c_byte_shifter.sv ====
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic                   clk,
    input  logic                   rst,
    input  i2c_master_pkg::phase_e phase_i,
    input  logic                   scl_rise_i,
    input  logic                   scl_fall_i,
    input  i2c_master_pkg::addr_t  addr_i,
    input  i2c_master_pkg::byte_t  data_i,
    input  logic                   sda_i,
    output logic                   sda_o,
    output logic                   byte_done_o,
    output logic                   ack_nack_o
);

    import i2c_master_pkg::*;

    addr_t      addr_q;
    byte_t      shreg;
    logic [3:0] bit_cnt;
    logic       ack_q;
    logic       in_byte;
    logic       in_ack;
    logic       load;

    assign in_byte = (phase_i == PH_ADDR) || (phase_i == PH_WRITE);
    assign in_ack  = (phase_i == PH_ADDR_ACK) || (phase_i == PH_WRITE_ACK);

    // Loads happen on the SCL fall that leaves the start or an acknowledged slot.
    assign load = scl_fall_i && ((phase_i == PH_START) || (in_ack && !ack_q));

    // address is followed while idle and frozen once the transfer starts.
    always_ff @(posedge clk) begin
        if (phase_i == PH_IDLE) begin
            addr_q <= addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= (phase_i == PH_START) ? {addr_q, WRITE_BIT} : data_i;
        end else if (scl_fall_i && in_byte && bit_cnt < 4'(BITS_PER_BYTE)) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    // bit_cnt holds the number of the bit on the line, 9 is the acknowledge slot.
    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt <= '0;
            ack_q   <= 1'b0;
        end else begin
            if (phase_i == PH_IDLE) begin
                bit_cnt <= '0;
            end else if (load) begin
                bit_cnt <= 4'd1;
            end else if (scl_fall_i && in_byte && bit_cnt <= 4'(BITS_PER_BYTE)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (byte_done_o) begin
                ack_q <= sda_i;
            end
        end
    end

    assign byte_done_o = in_byte && scl_rise_i && (bit_cnt == 4'(BITS_PER_BYTE + 1));
    assign ack_nack_o  = ack_q;

    always_comb begin
        case (phase_i)
            PH_START, PH_STOP: sda_o = 1'b0;
            PH_ADDR, PH_WRITE: sda_o = (bit_cnt > 4'(BITS_PER_BYTE)) ? 1'b1 : shreg[7];
            default:           sda_o = 1'b1;
        endcase
    end

    a_bit_cnt_range: assert property (
        @(posedge clk) disable iff (!rst)
        bit_cnt <= 4'(BITS_PER_BYTE + 1)
    );

endmodule

// ==== design/i2c_master_pkg.sv ====
package i2c_master_pkg;

    // one byte as it travels on SDA.
    typedef logic [7:0] byte_t;

    // 7-bit target address.
    typedef logic [6:0] addr_t;

    // number of data bytes in one write transfer.
    typedef logic [7:0] len_t;

    // half period of SCL, counted in clk cycles minus one.
    typedef logic [15:0] presc_t;

    localparam int unsigned BITS_PER_BYTE = 8;

    // read/write bit that follows the address, 0 selects a write.
    localparam logic WRITE_BIT = 1'b0;

    // bus phases of one transfer. The sequencer steps through them and the
    // shifter reads them to know what to drive on SDA.
    typedef enum logic [2:0] {
        // bus released, waiting for start_i.
        PH_IDLE,
        // SDA pulled low while SCL is high.
        PH_START,
        // address and write bit shifted out.
        PH_ADDR,
        // waiting for the SCL fall that ends the address acknowledge.
        PH_ADDR_ACK,
        // data byte shifted out.
        PH_WRITE,
        // waiting for the SCL fall that ends the data acknowledge.
        PH_WRITE_ACK,
        // SDA held low until SCL rises, then released.
        PH_STOP,
        // target answered NACK, bus released until reset.
        PH_ERROR
    } phase_e;

endpackage

// ==== design/i2c_master_top.sv ====
`timescale 1ns/1ps

module i2c_master_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  i2c_master_pkg::addr_t  addr_i,
    input  i2c_master_pkg::byte_t  data_i,
    input  i2c_master_pkg::len_t   data_len_i,
    input  i2c_master_pkg::presc_t prescaler_i,
    input  logic                   sda_i,
    output logic                   scl_o,
    output logic                   sda_o,
    output logic                   byte_taken_o,
    output logic                   valid_o,
    output logic                   error_o
);

    import i2c_master_pkg::*;

    logic   scl_en;
    logic   scl_rise;
    logic   scl_fall;
    logic   byte_done;
    logic   ack_nack;
    phase_e phase;

    i2c_scl_gen u_scl_gen (
        .clk         (clk),
        .rst         (rst),
        .scl_en_i    (scl_en),
        .prescaler_i (prescaler_i),
        .scl_o       (scl_o),
        .scl_rise_o  (scl_rise),
        .scl_fall_o  (scl_fall)
    );

    i2c_sequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .data_len_i   (data_len_i),
        .scl_rise_i   (scl_rise),
        .scl_fall_i   (scl_fall),
        .byte_done_i  (byte_done),
        .ack_nack_i   (ack_nack),
        .scl_en_o     (scl_en),
        .phase_o      (phase),
        .byte_taken_o (byte_taken_o),
        .valid_o      (valid_o),
        .error_o      (error_o)
    );

    i2c_byte_shifter u_byte_shifter (
        .clk         (clk),
        .rst         (rst),
        .phase_i     (phase),
        .scl_rise_i  (scl_rise),
        .scl_fall_i  (scl_fall),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .sda_i       (sda_i),
        .sda_o       (sda_o),
        .byte_done_o (byte_done),
        .ack_nack_o  (ack_nack)
    );

endmodule

// ==== design/i2c_scl_gen.sv ====
`timescale 1ns/1ps

module i2c_scl_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   scl_en_i,
    input  i2c_master_pkg::presc_t prescaler_i,
    output logic                   scl_o,
    output logic                   scl_rise_o,
    output logic                   scl_fall_o
);

    import i2c_master_pkg::*;

    presc_t presc_q;
    presc_t half_cnt;
    logic   scl_q;
    logic   rise_q;
    logic   fall_q;

    // the divider is taken while the clock is stopped, so the last value
    // seen before a transfer is the one used for all of it.
    always_ff @(posedge clk) begin
        if (!scl_en_i) begin
            presc_q <= prescaler_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            half_cnt <= '0;
            scl_q    <= 1'b1;
            rise_q   <= 1'b0;
            fall_q   <= 1'b0;
        end else if (!scl_en_i) begin
            half_cnt <= '0;
            scl_q    <= 1'b1;
            rise_q   <= 1'b0;
            fall_q   <= 1'b0;
        end else if (half_cnt == presc_q) begin
            // end of a half period.
            half_cnt <= '0;
            scl_q    <= ~scl_q;
            rise_q   <= ~scl_q;
            fall_q   <= scl_q;
        end else begin
            half_cnt <= half_cnt + 1'b1;
            rise_q   <= 1'b0;
            fall_q   <= 1'b0;
        end
    end

    assign scl_o      = scl_q;
    assign scl_rise_o = rise_q;
    assign scl_fall_o = fall_q;

    // The strobes mark the cycle in which scl has just changed.
    a_edges_exclusive: assert property (
        @(posedge clk) disable iff (!rst)
        !(scl_rise_o && scl_fall_o)
    );

endmodule

// ==== design/i2c_sequencer.sv ====
`timescale 1ns/1ps

module i2c_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  i2c_master_pkg::len_t   data_len_i,
    input  logic                   scl_rise_i,
    input  logic                   scl_fall_i,
    input  logic                   byte_done_i,
    input  logic                   ack_nack_i,
    output logic                   scl_en_o,
    output i2c_master_pkg::phase_e phase_o,
    output logic                   byte_taken_o,
    output logic                   valid_o,
    output logic                   error_o
);

    import i2c_master_pkg::*;

    phase_e phase_q;
    phase_e phase_d;
    len_t   bytes_left;
    logic   valid_q;
    logic   accept;
    logic   load_byte;
    logic   more_bytes;

    assign accept     = (phase_q == PH_IDLE) && start_i;
    assign more_bytes = (bytes_left != '0);

    // a data byte is taken at the SCL fall that closes an acknowledged slot,
    // unless the count says the transfer is over.
    always_comb begin
        load_byte = 1'b0;
        if (scl_fall_i && !ack_nack_i) begin
            if (phase_q == PH_ADDR_ACK) begin
                load_byte = 1'b1;
            end else if (phase_q == PH_WRITE_ACK && more_bytes) begin
                load_byte = 1'b1;
            end
        end
    end

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: begin
                if (start_i) begin
                    phase_d = PH_START;
                end
            end
            PH_START: begin
                if (scl_fall_i) begin
                    phase_d = PH_ADDR;
                end
            end
            PH_ADDR: begin
                if (byte_done_i) begin
                    phase_d = PH_ADDR_ACK;
                end
            end
            PH_ADDR_ACK: begin
                if (scl_fall_i) begin
                    phase_d = ack_nack_i ? PH_ERROR : PH_WRITE;
                end
            end
            PH_WRITE: begin
                if (byte_done_i) begin
                    phase_d = PH_WRITE_ACK;
                end
            end
            PH_WRITE_ACK: begin
                if (scl_fall_i) begin
                    if (ack_nack_i) begin
                        phase_d = PH_ERROR;
                    end else if (more_bytes) begin
                        phase_d = PH_WRITE;
                    end else begin
                        phase_d = PH_STOP;
                    end
                end
            end
            PH_STOP: begin
                // SDA is released once SCL is back high.
                if (scl_rise_i) begin
                    phase_d = PH_IDLE;
                end
            end
            default: begin
                phase_d = PH_ERROR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase_q    <= PH_IDLE;
            bytes_left <= '0;
            valid_q    <= 1'b0;
        end else begin
            phase_q <= phase_d;
            if (accept) begin
                bytes_left <= data_len_i;
            end else if (load_byte) begin
                bytes_left <= bytes_left - 1'b1;
            end
            if (accept) begin
                valid_q <= 1'b0;
            end else if (phase_q == PH_STOP && scl_rise_i) begin
                valid_q <= 1'b1;
            end
        end
    end

    // the bus clock runs for every phase of a transfer and stops in idle and error.
    assign scl_en_o     = (phase_q != PH_IDLE) && (phase_q != PH_ERROR);
    assign phase_o      = phase_q;
    assign byte_taken_o = load_byte;
    assign valid_o      = valid_q;
    assign error_o      = (phase_q == PH_ERROR);

    a_len_nonzero: assert property (
        @(posedge clk) disable iff (!rst)
        accept |-> (data_len_i != '0)
    );

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!rst)
        !(valid_o && error_o)
    );

endmodule

// ==== dv/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model (
    input  logic clk,
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_o
);

    import i2c_master_pkg::*;

    logic scl_q = 1'b1;
    logic sda_q = 1'b1;
    logic drive_q = 1'b1;
    logic bits[$];
    int   slot = 0;
    int   byte_idx = 0;
    int   nack_idx = -1;
    int   start_seen = 0;
    int   stop_seen = 0;

    assign sda_o = drive_q;

    // both lines are sampled on clk, so each bus event is seen one cycle late.
    always @(posedge clk) begin
        scl_q <= scl_i;
        sda_q <= sda_i;
        if (scl_q && scl_i && sda_q && !sda_i) begin
            start_seen++;
            slot     = 0;
            byte_idx = 0;
        end else if (scl_q && scl_i && !sda_q && sda_i) begin
            // the SCL rise in front of a stop carries no data bit.
            while (slot > 0) begin
                void'(bits.pop_back());
                slot--;
            end
            stop_seen++;
        end else if (!scl_q && scl_i) begin
            if (slot < BITS_PER_BYTE) begin
                bits.push_back(sda_i);
                slot++;
            end else begin
                slot = 0;
                byte_idx++;
            end
        end else if (scl_q && !scl_i) begin
            // byte 0 is the address, a refused byte leaves SDA released.
            drive_q <= !(slot == BITS_PER_BYTE && byte_idx != nack_idx);
        end
    end

    task automatic clear_record();
        bits.delete();
        start_seen = 0;
        stop_seen  = 0;
    endtask

    task automatic set_nack(input int idx);
        nack_idx = idx;
    endtask

    function automatic int bit_count();
        return bits.size();
    endfunction

    function automatic logic bit_at(input int idx);
        return bits[idx];
    endfunction

endmodule

// ==== dv/tb_i2c_master.sv ====
`timescale 1ns/1ps

module tb_i2c_master;

    import i2c_master_pkg::*;

    typedef logic bit_seq_t[$];

    logic   clk = 1'b0;
    logic   rst;
    logic   start;
    addr_t  addr;
    byte_t  data;
    len_t   data_len;
    presc_t presc;
    logic   scl;
    logic   master_sda;
    logic   slave_sda;
    logic   sda_line;
    logic   byte_taken;
    logic   valid;
    logic   error;

    byte_t  tx_bytes[$];
    int     lens[8];
    presc_t prescs[8];
    int     taken_cnt = 0;
    int     mismatches = 0;
    int     failures = 0;
    int     cycles = 0;
    int     cycle_limit;
    integer seed = 51050;
    logic   measure = 1'b0;
    logic   armed = 1'b0;
    logic   scl_last = 1'b1;
    int     run_len = 0;
    logic   exp_valid;
    logic   exp_error;
    len_t   exp_taken;
    logic   check_bits;
    event   check_ev;

    i2c_master_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start),
        .addr_i       (addr),
        .data_i       (data),
        .data_len_i   (data_len),
        .prescaler_i  (presc),
        .sda_i        (sda_line),
        .scl_o        (scl),
        .sda_o        (master_sda),
        .byte_taken_o (byte_taken),
        .valid_o      (valid),
        .error_o      (error)
    );

    i2c_slave_model slave_i (
        .clk   (clk),
        .scl_i (scl),
        .sda_i (sda_line),
        .sda_o (slave_sda)
    );

    // open-drain bus, either side pulls SDA low.
    assign sda_line = master_sda & slave_sda;

    always #2 clk = ~clk;

    function automatic int cycles_for(input int len, input int p);
        return 2 * (p + 1) * (9 * (len + 1) + 4);
    endfunction

    function automatic bit_seq_t expected_bits(input addr_t a, input byte_t bytes[$]);
        bit_seq_t seq;
        byte_t    cur;
        for (int b = 0; b <= bytes.size(); b++) begin
            cur = (b == 0) ? {a, WRITE_BIT} : bytes[b - 1];
            for (int i = BITS_PER_BYTE - 1; i >= 0; i--) begin
                seq.push_back(cur[i]);
            end
        end
        return seq;
    endfunction

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_count(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_period(input string name, input presc_t got, input presc_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        failures++;
    endtask

    always @(posedge clk) begin
        if (byte_taken) begin
            taken_cnt <= taken_cnt + 1;
        end
    end

    always @(negedge clk) begin
        data = (taken_cnt < tx_bytes.size()) ? tx_bytes[taken_cnt] : '0;
    end

    // half periods are measured between two SCL toggles of the same transfer.
    always @(posedge clk) begin
        if (!measure) begin
            armed <= 1'b0;
        end else if (scl !== scl_last) begin
            if (armed) begin
                compare_period("scl half period", presc_t'(run_len), presc + 1'b1);
            end
            armed   <= 1'b1;
            run_len <= 1;
        end else begin
            run_len <= run_len + 1;
        end
        scl_last <= scl;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("closing counts: %0d mismatches, %0d other errors", mismatches,
                     failures + 1);
            $display("Test failures found");
            $finish;
        end
    end

    always @(check_ev) begin
        bit_seq_t exp_seq;
        byte_t    got_b;
        byte_t    exp_b;
        if (check_bits) begin
            exp_seq = expected_bits(addr, tx_bytes);
            if (slave_i.bit_count() != exp_seq.size()) begin
                report_failure($sformatf("target received %0d bits instead of %0d",
                                         slave_i.bit_count(), exp_seq.size()));
            end else begin
                for (int b = 0; b < exp_seq.size() / BITS_PER_BYTE; b++) begin
                    for (int i = 0; i < BITS_PER_BYTE; i++) begin
                        got_b = {got_b[6:0], slave_i.bit_at(b * BITS_PER_BYTE + i)};
                        exp_b = {exp_b[6:0], exp_seq[b * BITS_PER_BYTE + i]};
                    end
                    compare_byte($sformatf("bus byte %0d", b), got_b, exp_b);
                end
            end
            if (slave_i.start_seen != 1 || slave_i.stop_seen != 1) begin
                report_failure("target did not see exactly one start and one stop");
            end
        end
        compare_flag("scl_o", scl, 1'b1);
        compare_flag("sda line", sda_line, 1'b1);
        compare_flag("valid_o", valid, exp_valid);
        compare_flag("error_o", error, exp_error);
        compare_count("byte_taken_o pulses", len_t'(taken_cnt), exp_taken);
    end

    task automatic request_check(input logic v, input logic e, input int taken,
                                 input logic bits);
        exp_valid  = v;
        exp_error  = e;
        exp_taken  = len_t'(taken);
        check_bits = bits;
        -> check_ev;
        @(negedge clk);
    endtask

    task automatic apply_reset();
        rst = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
    endtask

    // nack_at selects the refused byte, 0 is the address and -1 refuses none.
    task automatic run_transfer(input int len, input presc_t p, input int nack_at);
        tx_bytes.delete();
        for (int i = 0; i < len; i++) begin
            tx_bytes.push_back(byte_t'($random(seed)));
        end
        slave_i.clear_record();
        slave_i.set_nack(nack_at);
        taken_cnt = 0;
        @(negedge clk);
        addr     = addr_t'($random(seed));
        data_len = len_t'(len);
        presc    = p;
        start    = 1'b1;
        measure  = (nack_at < 0);
        @(negedge clk);
        start = 1'b0;
        while (!valid && !error) begin
            @(negedge clk);
        end
        measure = 1'b0;
        repeat (3) @(negedge clk);
        request_check(nack_at < 0, nack_at >= 0, (nack_at < 0) ? len : nack_at, nack_at < 0);
    endtask

    initial begin
        rst      = 1'b0;
        start    = 1'b0;
        addr     = '0;
        data     = '0;
        data_len = '0;
        presc    = '0;
        cycle_limit = 200 + cycles_for(1, 3) + cycles_for(3, 2) + cycles_for(4, 4);
        for (int t = 0; t < 8; t++) begin
            lens[t]     = 1 + $unsigned($random(seed)) % 6;
            prescs[t]   = presc_t'(1 + $unsigned($random(seed)) % 5);
            cycle_limit += cycles_for(lens[t], prescs[t]);
        end

        apply_reset();
        request_check(1'b0, 1'b0, 0, 1'b0);
        run_transfer(1, 16'd3, -1);
        for (int t = 0; t < 8; t++) begin
            run_transfer(lens[t], prescs[t], -1);
        end

        // an address NACK must leave the bus released until reset.
        run_transfer(3, 16'd2, 0);
        repeat (20) @(negedge clk);
        request_check(1'b0, 1'b1, 0, 1'b0);
        apply_reset();
        run_transfer(4, 16'd4, 2);

        $display("closing counts: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
design/i2c_master_pkg.sv
design/i2c_scl_gen.sv
design/i2c_sequencer.sv
design/i2c_byte_shifter.sv
design/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv
